//--- Makefile
TOP := tb_io_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

//--- rtl/gpio_port.sv
`include "io_consts.svh"

// gpio data and direction registers plus the led register
// every write is bit-masked with the issuing slot's mask
module gpio_port (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_req_t    req_q,
  input  io_pkg::io_word_t   wr_mask,
  input  io_pkg::io_word_t   pa_in,
  output io_pkg::io_word_t   pa_out,
  output io_pkg::io_word_t   pa_oe,
  output io_pkg::io_word_t   pmod_in_q,
  output io_pkg::led_word_t  leds
);

  logic pa_out_we;
  logic pa_oe_we;
  logic leds_we;

  // mask bit 1 takes the new bit, mask bit 0 keeps the old one
  function automatic io_pkg::io_word_t masked_merge(
    input io_pkg::io_word_t old_v,
    input io_pkg::io_word_t new_v,
    input io_pkg::io_word_t msk
  );
    return (old_v & ~msk) | (new_v & msk);
  endfunction

  assign pa_out_we = req_q.wr & req_q.addr[`IO_BIT_PMOD];
  assign pa_oe_we  = req_q.wr & req_q.addr[`IO_BIT_DIR];
  assign leds_we   = req_q.wr & req_q.addr[`IO_BIT_LEDS];

  // port output data
  always_ff @(posedge clk) begin
    if (pa_out_we) begin
      pa_out <= masked_merge(pa_out, req_q.data, wr_mask);
    end
  end

  // direction, all pins come up as inputs
  always_ff @(posedge clk) begin
    if (!resetq) begin
      pa_oe <= '0;
    end else if (pa_oe_we) begin
      pa_oe <= masked_merge(pa_oe, req_q.data, wr_mask);
    end
  end

  // leds use the low byte of data and mask
  always_ff @(posedge clk) begin
    if (leds_we) begin
      leds <= io_pkg::led_word_t'(masked_merge(io_pkg::io_word_t'(leds), req_q.data, wr_mask));
    end
  end

  // pins sampled once, read back from this register
  always_ff @(posedge clk) begin
    pmod_in_q <= pa_in;
  end

endmodule

//--- rtl/io_consts.svh
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// bus geometry
`define IO_WORD_BITS        16  // cpu data word
`define IO_SLOTS            4   // hardware threads sharing the bus
`define IO_LED_BITS         8
`define IO_SAMPLE_PTR_BITS  8   // 256 word sample memory

// one-hot device select bits in the io address
`define IO_BIT_PMOD         0   // gpio data
`define IO_BIT_DIR          1   // gpio direction, 1 = output
`define IO_BIT_LEDS         2
`define IO_BIT_TASK1        8   // task xt for slot 1
`define IO_BIT_TASK2        9   // task xt for slot 2
`define IO_BIT_TASK3        10  // task xt for slot 3
`define IO_BIT_SAMPLE       11  // sample memory data port
`define IO_BIT_MISC         13  // status on read, misc control on write
`define IO_BIT_TASK_FETCH   14  // read: own task, write: kill request
`define IO_BIT_MASK         15  // write: mask for next access, read: ticks

// misc word layout on writes to IO_BIT_MISC
// bits 7..0 carry the pointer preset value
`define IO_MISC_SET_WPTR    11
`define IO_MISC_SET_RPTR    10

`endif

//--- rtl/io_mask_stage.sv
`include "io_consts.svh"

// first pipeline stage: the cpu access is registered here, and each slot
// owns a mask word that qualifies its following access
module io_mask_stage (
  input  logic              clk,
  input  logic              resetq,
  input  io_pkg::io_req_t   io_req,
  output io_pkg::io_req_t   req_q,
  output io_pkg::io_word_t  wr_mask
);

  io_pkg::io_word_t mask_q [`IO_SLOTS]; // one stored mask per slot
  logic             access;             // captured cycle carries an access
  logic             mask_set;           // captured access loads a new mask

  // request capture, only the strobes need a defined value out of reset
  always_ff @(posedge clk) begin
    req_q <= io_req;
    if (!resetq) begin
      req_q.rd <= 1'b0;
      req_q.wr <= 1'b0;
    end
  end

  assign access   = req_q.rd | req_q.wr;
  assign mask_set = req_q.wr & req_q.addr[`IO_BIT_MASK];

  // the mask is consumed by the devices in the same cycle it is replaced,
  // so a new mask only ever reaches the slot's next access
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < `IO_SLOTS; i++) begin
        mask_q[i] <= '1; // unmasked
      end
    end else if (access) begin
      // any other access by the slot restores all ones
      mask_q[req_q.slot] <= mask_set ? req_q.data : '1;
    end
  end

  assign wr_mask = mask_q[req_q.slot]; // mask of the slot now at the devices

endmodule

//--- rtl/io_pkg.sv
`include "io_consts.svh"

package io_pkg;

  // plain data word on the io bus
  typedef logic [`IO_WORD_BITS-1:0] io_word_t;

  // device select, one bit per device (several may be set on a read)
  typedef logic [`IO_WORD_BITS-1:0] io_addr_t;

  typedef logic [$clog2(`IO_SLOTS)-1:0] slot_id_t; // which cpu slot issued the access

  typedef logic [`IO_LED_BITS-1:0] led_word_t;

  typedef logic [`IO_SAMPLE_PTR_BITS-1:0] sample_ptr_t; // wraps at the memory size

  typedef logic [`IO_SLOTS-1:0] kill_mask_t; // one restart request per slot

  // one io access as issued by the cpu
  // rd and wr are never set together
  typedef struct packed {
    logic     rd;
    logic     wr;
    slot_id_t slot;
    io_addr_t addr;
    io_word_t data;
  } io_req_t;

endpackage

//--- rtl/io_readback.sv
`include "io_consts.svh"

// tick counter, status word and the read-back or-bus
module io_readback (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_req_t    req_q,
  input  io_pkg::io_word_t   pmod_in_q,
  input  io_pkg::io_word_t   pmod_dir,
  input  io_pkg::led_word_t  leds,
  input  io_pkg::io_word_t   task_word1,
  input  io_pkg::io_word_t   task_word2,
  input  io_pkg::io_word_t   task_word3,
  input  io_pkg::io_word_t   task_fetch,
  input  io_pkg::io_word_t   sample_word,
  output io_pkg::io_word_t   io_din
);

  io_pkg::io_word_t ticks_q;
  io_pkg::io_word_t status_word;

  // free-running wall clock
  always_ff @(posedge clk) begin
    if (!resetq) begin
      ticks_q <= '0;
    end else begin
      ticks_q <= ticks_q + 1'b1;
    end
  end

  // msb says "not slot 0", everything else reads zero
  assign status_word = {(req_q.slot != '0), {(`IO_WORD_BITS - 1){1'b0}}};

  // every selected source is ORed in; decodes from the address alone
  always_comb begin
    io_din = '0;
    if (req_q.addr[`IO_BIT_PMOD])       io_din |= pmod_in_q;
    if (req_q.addr[`IO_BIT_DIR])        io_din |= pmod_dir;
    if (req_q.addr[`IO_BIT_LEDS])       io_din |= io_pkg::io_word_t'(leds); // low byte
    if (req_q.addr[`IO_BIT_TASK1])      io_din |= task_word1;
    if (req_q.addr[`IO_BIT_TASK2])      io_din |= task_word2;
    if (req_q.addr[`IO_BIT_TASK3])      io_din |= task_word3;
    if (req_q.addr[`IO_BIT_SAMPLE])     io_din |= sample_word;
    if (req_q.addr[`IO_BIT_MISC])       io_din |= status_word;
    if (req_q.addr[`IO_BIT_TASK_FETCH]) io_din |= task_fetch;
    if (req_q.addr[`IO_BIT_MASK])       io_din |= ticks_q;  // ticks on the read side
  end

endmodule

//--- rtl/io_subsystem.sv
// io block top: capture stage in front, devices and read-back behind it
module io_subsystem (
  input  logic                clk,
  input  logic                resetq,
  input  io_pkg::io_req_t     io_req,
  input  io_pkg::io_word_t    pa_in,
  output io_pkg::io_word_t    pa_out,
  output io_pkg::io_word_t    pa_oe,
  output io_pkg::led_word_t   leds,
  output io_pkg::io_word_t    io_din,
  output io_pkg::kill_mask_t  kill_slot_rq
);

  io_pkg::io_req_t   req_q;      // access now at the devices
  io_pkg::io_word_t  wr_mask;    // that access's slot mask
  io_pkg::io_word_t  pmod_in_q;
  io_pkg::io_word_t  task_word1;
  io_pkg::io_word_t  task_word2;
  io_pkg::io_word_t  task_word3;
  io_pkg::io_word_t  task_fetch;
  io_pkg::io_word_t  sample_word;

  io_mask_stage u_mask_stage (
    .clk     (clk),
    .resetq  (resetq),
    .io_req  (io_req),
    .req_q   (req_q),
    .wr_mask (wr_mask)
  );

  gpio_port u_gpio (
    .clk       (clk),
    .resetq    (resetq),
    .req_q     (req_q),
    .wr_mask   (wr_mask),
    .pa_in     (pa_in),
    .pa_out    (pa_out),
    .pa_oe     (pa_oe),
    .pmod_in_q (pmod_in_q),
    .leds      (leds)
  );

  task_scheduler u_tasks (
    .clk          (clk),
    .resetq       (resetq),
    .req_q        (req_q),
    .task_word1   (task_word1),
    .task_word2   (task_word2),
    .task_word3   (task_word3),
    .task_fetch   (task_fetch),
    .kill_slot_rq (kill_slot_rq)
  );

  sample_ram u_samples (
    .clk         (clk),
    .resetq      (resetq),
    .req_q       (req_q),
    .sample_word (sample_word)
  );

  // direction register reads back through pa_oe
  io_readback u_readback (
    .clk         (clk),
    .resetq      (resetq),
    .req_q       (req_q),
    .pmod_in_q   (pmod_in_q),
    .pmod_dir    (pa_oe),
    .leds        (leds),
    .task_word1  (task_word1),
    .task_word2  (task_word2),
    .task_word3  (task_word3),
    .task_fetch  (task_fetch),
    .sample_word (sample_word),
    .io_din      (io_din)
  );

endmodule

//--- rtl/sample_ram.sv
`include "io_consts.svh"

// 256x16 sample store with independent auto-incrementing pointers
module sample_ram (
  input  logic              clk,
  input  logic              resetq,
  input  io_pkg::io_req_t   req_q,
  output io_pkg::io_word_t  sample_word
);

  localparam int DEPTH = 1 << `IO_SAMPLE_PTR_BITS;

  io_pkg::io_word_t     mem_q [DEPTH];
  io_pkg::sample_ptr_t  wptr_q;
  io_pkg::sample_ptr_t  rptr_q;
  io_pkg::sample_ptr_t  preset_ptr;
  logic                 misc_wr;
  logic                 set_wptr;
  logic                 set_rptr;
  logic                 sample_wr;
  logic                 sample_rd;

  assign misc_wr    = req_q.wr & req_q.addr[`IO_BIT_MISC];
  assign set_wptr   = misc_wr & req_q.data[`IO_MISC_SET_WPTR];
  assign set_rptr   = misc_wr & req_q.data[`IO_MISC_SET_RPTR];
  assign preset_ptr = req_q.data[`IO_SAMPLE_PTR_BITS-1:0]; // both presets share the value
  assign sample_wr  = req_q.wr & req_q.addr[`IO_BIT_SAMPLE];
  assign sample_rd  = req_q.rd & req_q.addr[`IO_BIT_SAMPLE];

  // pointers wrap by plain overflow
  always_ff @(posedge clk) begin
    if (!resetq) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (set_wptr) begin
        wptr_q <= preset_ptr;
      end else if (sample_wr) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (set_rptr) begin
        rptr_q <= preset_ptr;
      end else if (sample_rd) begin
        rptr_q <= rptr_q + 1'b1; // step after the word went out
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_wr) begin
      mem_q[wptr_q] <= req_q.data;
    end
  end

  assign sample_word = mem_q[rptr_q]; // current word, ready for the next read

endmodule

//--- rtl/task_scheduler.sv
`include "io_consts.svh"

// task table for slots 1..3
// slot 0 never gets a task, it runs the main loop
module task_scheduler (
  input  logic                clk,
  input  logic                resetq,
  input  io_pkg::io_req_t     req_q,
  output io_pkg::io_word_t    task_word1,
  output io_pkg::io_word_t    task_word2,
  output io_pkg::io_word_t    task_word3,
  output io_pkg::io_word_t    task_fetch,
  output io_pkg::kill_mask_t  kill_slot_rq
);

  localparam int TASK_SLOTS = `IO_SLOTS - 1;

  io_pkg::io_word_t  task_q [TASK_SLOTS]; // entry i belongs to slot i+1
  io_pkg::slot_id_t  own_idx;             // table entry of the captured slot
  logic              own_slot;            // captured slot has a table entry
  logic              fetch_rd;
  logic              kill_wr;

  assign own_idx  = io_pkg::slot_id_t'(req_q.slot - 2'd1);
  assign own_slot = (req_q.slot != '0);
  assign fetch_rd = req_q.rd & req_q.addr[`IO_BIT_TASK_FETCH];
  assign kill_wr  = req_q.wr & req_q.addr[`IO_BIT_TASK_FETCH];

  // any slot may assign any task word
  // lsb of an xt marks a run-once task, cleared by its first fetch
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < TASK_SLOTS; i++) begin
        task_q[i] <= '0; // no slot restarts a stale task
      end
    end else if (req_q.wr) begin
      for (int i = 0; i < TASK_SLOTS; i++) begin
        if (req_q.addr[`IO_BIT_TASK1 + i]) begin
          task_q[i] <= req_q.data;
        end
      end
    end else if (fetch_rd && own_slot && task_q[own_idx][0]) begin
      task_q[own_idx] <= '0;
    end
  end

  // kill request lives exactly one cycle after the write is at the devices
  always_ff @(posedge clk) begin
    if (!resetq) begin
      kill_slot_rq <= '0;
    end else begin
      kill_slot_rq <= kill_wr ? req_q.data[`IO_SLOTS-1:0] : '0;
    end
  end

  // a valid xt is even, so the run-once flag is hidden from the fetch
  always_comb begin
    if (own_slot) begin
      task_fetch = {task_q[own_idx][`IO_WORD_BITS-1:1], 1'b0};
    end else begin
      task_fetch = '0; // slot 0 spins on nothing
    end
  end

  assign task_word1 = task_q[0];
  assign task_word2 = task_q[1];
  assign task_word3 = task_q[2];

endmodule

//--- sources.f
+incdir+rtl
rtl/io_pkg.sv
rtl/io_mask_stage.sv
rtl/gpio_port.sv
rtl/task_scheduler.sv
rtl/sample_ram.sv
rtl/io_readback.sv
rtl/io_subsystem.sv
verif/tb_io_subsystem.sv

//--- verif/tb_io_subsystem.sv
`include "io_consts.svh"

module tb_io_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES  = 16;
  localparam int ACCESS_CYCLES = 4;   // longest bus task, kill write included
  localparam int TEST_ACCESSES = 90;  // all accesses of all tests, rounded up
  localparam int GAP_CYCLES    = 64;  // idle gaps between tick reads
  localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + TEST_ACCESSES * ACCESS_CYCLES + GAP_CYCLES);

  logic               clk;
  logic               resetq;
  io_pkg::io_req_t    io_req;
  io_pkg::io_word_t   pa_in;
  io_pkg::io_word_t   pa_out;
  io_pkg::io_word_t   pa_oe;
  io_pkg::led_word_t  leds;
  io_pkg::io_word_t   io_din;
  io_pkg::kill_mask_t kill_slot_rq;

  // reference model of the visible state
  io_pkg::io_word_t    exp_pa_out;
  io_pkg::io_word_t    exp_pa_oe;
  io_pkg::led_word_t   exp_leds;
  io_pkg::kill_mask_t  exp_kill;
  io_pkg::io_word_t    exp_task [4];     // entry 0 unused, always zero
  io_pkg::io_word_t    mask_model [4];
  io_pkg::io_word_t    sample_model [256];
  io_pkg::sample_ptr_t wptr_model;
  io_pkg::sample_ptr_t rptr_model;
  logic                out_known;        // pa_out and leds have no reset
  logic                led_known;
  logic                rd_check;         // io_din is checked at the coming edge
  io_pkg::io_word_t    exp_din;

  logic [31:0] lfsr_q = 32'hd09c_52ab;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  io_subsystem UUT (
    .clk          (clk),
    .resetq       (resetq),
    .io_req       (io_req),
    .pa_in        (pa_in),
    .pa_out       (pa_out),
    .pa_oe        (pa_oe),
    .leds         (leds),
    .io_din       (io_din),
    .kill_slot_rq (kill_slot_rq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  a_read_data: assert property (@(posedge clk) disable iff (!resetq)
    rd_check |-> io_din == exp_din)
    else begin
      $display("Mismatch io_din: got %h expected %h", $sampled(io_din), $sampled(exp_din));
      errors++;
    end

  a_pa_out: assert property (@(posedge clk) disable iff (!resetq)
    out_known |-> pa_out == exp_pa_out)
    else begin
      $display("Mismatch pa_out: got %h expected %h", $sampled(pa_out), $sampled(exp_pa_out));
      errors++;
    end

  a_pa_oe: assert property (@(posedge clk) disable iff (!resetq) pa_oe == exp_pa_oe)
    else begin
      $display("Mismatch pa_oe: got %h expected %h", $sampled(pa_oe), $sampled(exp_pa_oe));
      errors++;
    end

  a_leds: assert property (@(posedge clk) disable iff (!resetq)
    led_known |-> leds == exp_leds)
    else begin
      $display("Mismatch leds: got %h expected %h", $sampled(leds), $sampled(exp_leds));
      errors++;
    end

  // one-cycle pulse, zero at every other edge
  a_kill: assert property (@(posedge clk) disable iff (!resetq) kill_slot_rq == exp_kill)
    else begin
      $display("Mismatch kill_slot_rq: got %h expected %h", $sampled(kill_slot_rq),
               $sampled(exp_kill));
      errors++;
    end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic io_pkg::io_word_t rand_bits(input int n);
    io_pkg::io_word_t w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[14:0], next_bit()}; // one step per bit
    end
    return w;
  endfunction

  function automatic io_pkg::io_addr_t onehot(input int b);
    return io_pkg::io_addr_t'(1) << b;
  endfunction

  // effect of a completed write on the model, mask of the issuing slot applies
  function automatic void apply_write(input io_pkg::slot_id_t slot, input io_pkg::io_addr_t addr,
                                      input io_pkg::io_word_t data);
    io_pkg::io_word_t m;
    m = mask_model[slot];
    if (addr[`IO_BIT_PMOD]) begin
      exp_pa_out = (exp_pa_out & ~m) | (data & m);
      out_known = 1'b1;
    end
    if (addr[`IO_BIT_DIR]) exp_pa_oe = (exp_pa_oe & ~m) | (data & m);
    if (addr[`IO_BIT_LEDS]) begin
      exp_leds = (exp_leds & ~m[7:0]) | (data[7:0] & m[7:0]); // low byte only
      led_known = 1'b1;
    end
    for (int k = 1; k < 4; k++) begin
      if (addr[`IO_BIT_TASK1 + k - 1]) exp_task[k] = data;
    end
    if (addr[`IO_BIT_MISC]) begin
      if (data[`IO_MISC_SET_WPTR]) wptr_model = data[7:0];
      if (data[`IO_MISC_SET_RPTR]) rptr_model = data[7:0];
    end
    if (addr[`IO_BIT_SAMPLE]) begin
      sample_model[wptr_model] = data;
      wptr_model++;                       // wraps at 256
    end
    if (addr[`IO_BIT_TASK_FETCH]) exp_kill = data[3:0];
    mask_model[slot] = addr[`IO_BIT_MASK] ? data : 16'hffff; // mask lives one access
  endfunction

  task automatic io_write(input io_pkg::slot_id_t slot, input io_pkg::io_addr_t addr,
                          input io_pkg::io_word_t data);
    @(negedge clk);
    io_req.rd   = 1'b0;
    io_req.wr   = 1'b1;
    io_req.slot = slot;
    io_req.addr = addr;
    io_req.data = data;
    @(negedge clk);
    io_req = '0;              // write now at the devices
    @(negedge clk);
    apply_write(slot, addr, data); // took effect at the last edge
    if (addr[`IO_BIT_TASK_FETCH]) begin
      @(negedge clk);
      exp_kill = '0;          // pulse is over
    end
  endtask

  // got is io_din in the cycle the read sits at the devices
  task automatic io_read(input io_pkg::slot_id_t slot, input io_pkg::io_addr_t addr,
                         input io_pkg::io_word_t exp, input logic check,
                         output io_pkg::io_word_t got);
    @(negedge clk);
    io_req.rd   = 1'b1;
    io_req.wr   = 1'b0;
    io_req.slot = slot;
    io_req.addr = addr;
    io_req.data = '0;
    @(negedge clk);
    io_req   = '0;
    rd_check = check;
    exp_din  = exp;
    got      = io_din;
    @(negedge clk);
    rd_check = 1'b0;
    mask_model[slot] = 16'hffff; // a read also uses up the mask
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %-10s passed", name);
    end else begin
      tests_failed++;
      $display("test %-10s FAILED with %0d errors", name, errors - err0);
    end
  endtask

  task automatic gpio_and_leds();
    int err0;
    io_pkg::io_word_t w;
    io_pkg::io_word_t got;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      io_write(2'd0, onehot(`IO_BIT_PMOD), rand_bits(16));
      io_write(2'd0, onehot(`IO_BIT_DIR), rand_bits(16));
      io_read(2'd0, onehot(`IO_BIT_DIR), exp_pa_oe, 1'b1, got);
      w = rand_bits(16);
      pa_in = ~w;
      fork
        io_read(2'd0, onehot(`IO_BIT_PMOD), w, 1'b1, got);
        begin
          @(negedge clk);
          pa_in = w;          // only on the pins in the capture cycle
          @(negedge clk);
          pa_in = ~w;         // pins move on while the read is at the devices
        end
      join
    end
    for (int i = 0; i < 2; i++) begin
      io_write(2'd0, onehot(`IO_BIT_LEDS), rand_bits(16));
      io_read(2'd0, onehot(`IO_BIT_LEDS), {8'h00, exp_leds}, 1'b1, got);
    end
    finish_test("gpio", err0);
  endtask

  task automatic write_masks();
    int err0;
    io_pkg::io_word_t got;
    err0 = errors;
    io_write(2'd1, onehot(`IO_BIT_MASK), rand_bits(16));
    io_write(2'd1, onehot(`IO_BIT_PMOD), rand_bits(16)); // merged under the mask
    io_write(2'd1, onehot(`IO_BIT_PMOD), rand_bits(16)); // full write again
    io_write(2'd2, onehot(`IO_BIT_MASK), rand_bits(16));
    io_write(2'd1, onehot(`IO_BIT_PMOD), rand_bits(16)); // other slot, unmasked
    io_write(2'd2, onehot(`IO_BIT_DIR), rand_bits(16));
    io_write(2'd3, onehot(`IO_BIT_MASK), rand_bits(16));
    io_read(2'd3, onehot(`IO_BIT_DIR), exp_pa_oe, 1'b1, got);
    io_write(2'd3, onehot(`IO_BIT_LEDS), rand_bits(16)); // mask gone after the read
    finish_test("mask", err0);
  endtask

  task automatic fetch_task(input io_pkg::slot_id_t k);
    io_pkg::io_word_t exp;
    io_pkg::io_word_t got;
    exp = (k == 2'd0) ? 16'h0000 : {exp_task[k][15:1], 1'b0};
    io_read(k, onehot(`IO_BIT_TASK_FETCH), exp, 1'b1, got);
    if (exp_task[k][0]) exp_task[k] = '0; // run-once task consumed
  endtask

  task automatic task_table();
    int err0;
    io_pkg::io_word_t xt2;
    io_pkg::io_word_t got;
    err0 = errors;
    xt2 = rand_bits(16) & 16'hfffe;
    io_write(2'd0, onehot(`IO_BIT_TASK1), rand_bits(16) | 16'h0001); // odd, read once
    io_write(2'd0, onehot(`IO_BIT_TASK2), xt2);
    io_write(2'd0, onehot(`IO_BIT_TASK3), rand_bits(16));
    for (int k = 1; k < 4; k++) begin
      io_read(2'd0, onehot(`IO_BIT_TASK1 + k - 1), exp_task[k], 1'b1, got);
    end
    for (int k = 0; k < 4; k++) begin
      fetch_task(io_pkg::slot_id_t'(k));
    end
    fetch_task(2'd2);
    io_read(2'd0, onehot(`IO_BIT_TASK1), 16'h0000, 1'b1, got);
    io_read(2'd0, onehot(`IO_BIT_TASK2), xt2, 1'b1, got);
    finish_test("tasks", err0);
  endtask

  task automatic kill_pulse();
    int err0;
    err0 = errors;
    io_write(2'd1, onehot(`IO_BIT_TASK_FETCH), 16'h000f);
    io_write(2'd0, onehot(`IO_BIT_TASK_FETCH), rand_bits(16));
    io_write(2'd3, onehot(`IO_BIT_TASK_FETCH), rand_bits(16));
    finish_test("kill", err0);
  endtask

  // preset both pointers to p, then n writes and n reads in order
  task automatic sample_run(input io_pkg::sample_ptr_t p, input int n);
    io_pkg::io_word_t got;
    io_write(2'd0, onehot(`IO_BIT_MISC),
             onehot(`IO_MISC_SET_WPTR) | onehot(`IO_MISC_SET_RPTR) | {8'h00, p});
    for (int i = 0; i < n; i++) begin
      io_write(2'd0, onehot(`IO_BIT_SAMPLE), rand_bits(16));
    end
    for (int i = 0; i < n; i++) begin
      io_read(2'd0, onehot(`IO_BIT_SAMPLE), sample_model[rptr_model], 1'b1, got);
      rptr_model++;
    end
  endtask

  task automatic sample_memory();
    int err0;
    err0 = errors;
    sample_run(io_pkg::sample_ptr_t'(rand_bits(8)), 6);
    sample_run(8'hfb, 10);    // crosses 255
    finish_test("samples", err0);
  endtask

  task automatic ticks_and_status();
    int err0;
    int gap;
    io_pkg::io_word_t first;
    io_pkg::io_word_t got;
    io_pkg::io_word_t all_exp;
    err0 = errors;
    for (int i = 0; i < 2; i++) begin
      gap = int'(rand_bits(5));
      io_read(2'd0, onehot(`IO_BIT_MASK), '0, 1'b0, first);
      repeat (gap) @(negedge clk);
      // issue points are gap + 3 cycles apart
      io_read(2'd0, onehot(`IO_BIT_MASK), first + io_pkg::io_word_t'(gap + 3), 1'b1, got);
    end
    for (int k = 0; k < 4; k++) begin
      io_read(io_pkg::slot_id_t'(k), onehot(`IO_BIT_MISC), (k == 0) ? 16'h0000 : 16'h8000,
              1'b1, got);
    end
    all_exp = exp_pa_oe | {8'h00, exp_leds} | exp_task[2] | exp_task[3] | 16'h8000;
    io_read(2'd2, onehot(`IO_BIT_DIR) | onehot(`IO_BIT_LEDS) | onehot(`IO_BIT_TASK2) |
            onehot(`IO_BIT_TASK3) | onehot(`IO_BIT_MISC), all_exp, 1'b1, got);
    finish_test("ticks", err0);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    resetq     = 1'b0;
    io_req     = '0;
    pa_in      = '0;
    exp_pa_out = '0;
    exp_pa_oe  = '0;
    exp_leds   = '0;
    exp_kill   = '0;
    wptr_model = '0;
    rptr_model = '0;
    out_known  = 1'b0;
    led_known  = 1'b0;
    rd_check   = 1'b0;
    exp_din    = '0;
    for (int k = 0; k < 4; k++) begin
      exp_task[k]   = '0;
      mask_model[k] = 16'hffff;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    resetq = 1'b1;
    gpio_and_leds();
    write_masks();
    task_table();
    kill_pulse();
    sample_memory();
    ticks_and_status();
    repeat (2) @(negedge clk);
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
